/* controlUnitPkg.sv */
//////////////////////////////
// Shared widths, state numbers, sequencing enums
// and microword structs for the control unit
//////////////////////////////
package controlUnitPkg;

	localparam int StateWidth = 5;
	localparam int OpcodeWidth = 3;
	localparam int AluOpWidth = 6;

	typedef logic [StateWidth-1:0] state_t;
	typedef logic [OpcodeWidth-1:0] opcode_t;

	// Fetch routine
	localparam state_t ResetState = 5'd0;
	localparam state_t FetchState = 5'd1;
	localparam state_t FetchWaitState = 5'd2;
	localparam state_t IrLoadState = 5'd3;

	// ALU and default routines
	localparam state_t AluRegState = 5'd5;
	localparam state_t AluImmState = 5'd7;
	localparam state_t DefaultState = 5'd10;

	// Memory routines
	localparam state_t LoadAddrState = 5'd16;
	localparam state_t LoadWaitState = 5'd17;
	localparam state_t LoadWriteState = 5'd18;
	localparam state_t StoreAddrState = 5'd20;
	localparam state_t StoreDataState = 5'd21;
	localparam state_t StoreWaitState = 5'd22;

	// Conditional branch
	localparam state_t BranchState = 5'd25;
	localparam state_t BranchTakeState = 5'd26;

	typedef enum logic [2:0]
	{
		SeqDispatch = 3'd0,
		SeqIncrement = 3'd1,
		SeqJump = 3'd2,
		SeqWaitIncrement = 3'd3,
		SeqBranch = 3'd4,
		// Hold until the condition, then go to target
		SeqWaitJump = 3'd5
	} nextSel_e;

	typedef enum logic [1:0]
	{
		CondMoc = 2'd0,
		CondBranch = 2'd1,
		CondAlways = 2'd2
	} condSel_e;

	// Datapath control word
	typedef struct packed
	{
		logic marLd;
		logic mdrLd;
		logic irLd;
		logic pcLd;
		logic npcLd;
		logic rfLd;
		logic frLd;
		logic memEnable;
		// High for a memory read
		logic readWrite;
		logic muxA;
		logic [1:0] muxB;
		logic muxC;
		logic [1:0] muxD;
		logic muxE;
		logic muxF;
		logic muxG;
		logic [AluOpWidth-1:0] aluOp;
		logic carryIn;
	} datapathCtrl_t;

	typedef struct packed
	{
		nextSel_e nextSel;
		condSel_e condSel;
		logic invert;
		state_t target;
	} seqCtrl_t;

	typedef struct packed
	{
		datapathCtrl_t ctrl;
		seqCtrl_t seq;
	} microWord_t;

endpackage

/* instructionDecoder.sv */
//////////////////////////////
// Opcode class to routine entry state
//////////////////////////////
module instructionDecoder
(
	input controlUnitPkg::opcode_t opcode,
	output controlUnitPkg::state_t entry
);

	always_comb
	begin
		case (opcode)
			3'd0:
				entry = controlUnitPkg::AluRegState;
			3'd1:
				entry = controlUnitPkg::AluImmState;
			3'd2:
				entry = controlUnitPkg::LoadAddrState;
			3'd3:
				entry = controlUnitPkg::StoreAddrState;
			3'd4:
				entry = controlUnitPkg::BranchState;
			// Unknown classes still return to fetch
			default:
				entry = controlUnitPkg::DefaultState;
		endcase
	end

endmodule

/* microstore.sv */
//////////////////////////////
// Microprogram table with one microword per state
//////////////////////////////
module microstore
(
	input logic reset,
	input controlUnitPkg::state_t state,
	output controlUnitPkg::microWord_t word
);

	function automatic controlUnitPkg::seqCtrl_t seqOf
	(
		input controlUnitPkg::nextSel_e nextSel,
		input controlUnitPkg::condSel_e condSel,
		input controlUnitPkg::state_t target
	);
		controlUnitPkg::seqCtrl_t s;
		s.nextSel = nextSel;
		s.condSel = condSel;
		s.invert = 1'b0;
		s.target = target;
		return s;
	endfunction

	always_comb
	begin
		// Unused states get an idle word and jump back to fetch
		word = '0;
		word.seq = seqOf(controlUnitPkg::SeqJump, controlUnitPkg::CondAlways,
			controlUnitPkg::FetchState);
		case (state)
			controlUnitPkg::FetchState:
			begin
				// MAR and PC both take the PC path plus 4
				word.ctrl.marLd = 1'b1;
				word.ctrl.pcLd = 1'b1;
				word.ctrl.muxB = 2'b11;
				word.ctrl.muxD = 2'b01;
				word.ctrl.muxE = 1'b1;
				word.ctrl.aluOp = 6'b000100;
				word.seq = seqOf(controlUnitPkg::SeqIncrement, controlUnitPkg::CondAlways,
					controlUnitPkg::ResetState);
			end
			controlUnitPkg::FetchWaitState:
			begin
				word.ctrl.memEnable = 1'b1;
				word.ctrl.readWrite = 1'b1;
				word.seq = seqOf(controlUnitPkg::SeqWaitIncrement, controlUnitPkg::CondMoc,
					controlUnitPkg::ResetState);
			end
			controlUnitPkg::IrLoadState:
			begin
				word.ctrl.irLd = 1'b1;
				word.ctrl.npcLd = 1'b1;
				word.seq = seqOf(controlUnitPkg::SeqDispatch, controlUnitPkg::CondAlways,
					controlUnitPkg::ResetState);
			end
			controlUnitPkg::AluRegState, controlUnitPkg::AluImmState:
			begin
				word.ctrl.rfLd = 1'b1;
				word.ctrl.frLd = 1'b1;
				word.ctrl.muxC = 1'b1;
				// Immediate operand on the B side
				word.ctrl.muxB = (state == controlUnitPkg::AluImmState) ? 2'b01 : 2'b00;
			end
			controlUnitPkg::LoadAddrState, controlUnitPkg::StoreAddrState:
			begin
				// Base plus offset into MAR
				word.ctrl.marLd = 1'b1;
				word.ctrl.muxB = 2'b01;
				word.ctrl.aluOp = 6'b000100;
				word.seq = seqOf(controlUnitPkg::SeqIncrement, controlUnitPkg::CondAlways,
					controlUnitPkg::ResetState);
			end
			controlUnitPkg::LoadWaitState:
			begin
				word.ctrl.mdrLd = 1'b1;
				word.ctrl.memEnable = 1'b1;
				word.ctrl.readWrite = 1'b1;
				word.seq = seqOf(controlUnitPkg::SeqWaitIncrement, controlUnitPkg::CondMoc,
					controlUnitPkg::ResetState);
			end
			controlUnitPkg::LoadWriteState:
			begin
				word.ctrl.rfLd = 1'b1;
				word.ctrl.muxB = 2'b10;
				word.ctrl.aluOp = 6'b001010;
			end
			controlUnitPkg::StoreDataState:
			begin
				word.ctrl.mdrLd = 1'b1;
				word.ctrl.muxA = 1'b1;
				word.ctrl.muxG = 1'b1;
				word.ctrl.aluOp = 6'b001000;
				word.seq = seqOf(controlUnitPkg::SeqIncrement, controlUnitPkg::CondAlways,
					controlUnitPkg::ResetState);
			end
			controlUnitPkg::StoreWaitState:
			begin
				// Write cycle with readWrite low
				word.ctrl.memEnable = 1'b1;
				word.seq = seqOf(controlUnitPkg::SeqWaitJump, controlUnitPkg::CondMoc,
					controlUnitPkg::FetchState);
			end
			controlUnitPkg::BranchState:
				word.seq = seqOf(controlUnitPkg::SeqBranch, controlUnitPkg::CondBranch,
					controlUnitPkg::BranchTakeState);
			controlUnitPkg::BranchTakeState:
			begin
				// nPC plus displacement into PC
				word.ctrl.pcLd = 1'b1;
				word.ctrl.npcLd = 1'b1;
				word.ctrl.muxF = 1'b1;
				word.ctrl.aluOp = 6'b000100;
			end
			default:
			begin
				// Reset, default routine and unused states
			end
		endcase
		// No datapath load while in reset
		if (reset)
			word.ctrl = '0;
	end

endmodule

/* microSequencer.sv */
//////////////////////////////
// State register, incrementer
// and next-state selection
//////////////////////////////
module microSequencer
(
	input logic clk,
	input logic reset,
	input controlUnitPkg::seqCtrl_t seq,
	input controlUnitPkg::state_t entry,
	input logic moc,
	input logic cond,
	output controlUnitPkg::state_t state
);

	controlUnitPkg::state_t stateInc;
	controlUnitPkg::state_t nextState;
	logic condSelected;
	logic condTrue;

	assign stateInc = state + controlUnitPkg::state_t'(1);

	always_comb
	begin
		case (seq.condSel)
			controlUnitPkg::CondMoc:
				condSelected = moc;
			controlUnitPkg::CondBranch:
				condSelected = cond;
			default:
				condSelected = 1'b1;
		endcase
	end

	assign condTrue = condSelected ^ seq.invert;

	always_comb
	begin
		case (seq.nextSel)
			controlUnitPkg::SeqDispatch:
				nextState = entry;
			controlUnitPkg::SeqIncrement:
				nextState = stateInc;
			controlUnitPkg::SeqJump:
				nextState = seq.target;
			// Wait modes hold the state until the condition
			controlUnitPkg::SeqWaitIncrement:
				nextState = condTrue ? stateInc : state;
			controlUnitPkg::SeqWaitJump:
				nextState = condTrue ? seq.target : state;
			controlUnitPkg::SeqBranch:
				nextState = condTrue ? seq.target : controlUnitPkg::FetchState;
			default:
				nextState = controlUnitPkg::FetchState;
		endcase
	end

	always_ff @(posedge clk)
	begin
		if (reset)
			state <= controlUnitPkg::ResetState;
		else
			state <= nextState;
	end

endmodule

/* controlUnit.sv */
//////////////////////////////
// Control unit top level
// Decoder, microstore and sequencer loop
//////////////////////////////
module controlUnit
(
	input logic clk,
	input logic reset,
	input controlUnitPkg::opcode_t opcode,
	input logic moc,
	input logic cond,
	output controlUnitPkg::datapathCtrl_t ctrl,
	output controlUnitPkg::state_t state
);

	controlUnitPkg::microWord_t word;
	controlUnitPkg::state_t entry;

	instructionDecoder decoder_i
	(
		.opcode(opcode),
		.entry(entry)
	);

	microstore microstore_i
	(
		.reset(reset),
		.state(state),
		.word(word)
	);

	microSequencer sequencer_i
	(
		.clk(clk),
		.reset(reset),
		.seq(word.seq),
		.entry(entry),
		.moc(moc),
		.cond(cond),
		.state(state)
	);

	// Control word of the current state
	assign ctrl = word.ctrl;

endmodule

/* clockGen.sv */
//////////////////////////////
// Free-running testbench clock
//////////////////////////////
module clockGen
#(
	parameter int Period = 8
)
(
	output logic clk
);

	initial
		clk = 1'b0;

	always #(Period / 2) clk = ~clk;

endmodule

/* controlUnitChecker.sv */
//////////////////////////////
// Sequencing assertions, bound
// into the microsequencer
//////////////////////////////
module controlUnitChecker
(
	input logic clk,
	input logic reset,
	input logic moc,
	input controlUnitPkg::state_t state
);

	logic inWait;
	logic inUse;

	assign inWait = (state == controlUnitPkg::FetchWaitState) ||
		(state == controlUnitPkg::LoadWaitState) || (state == controlUnitPkg::StoreWaitState);

	// States that belong to a routine
	assign inUse = (state <= controlUnitPkg::IrLoadState) ||
		(state == controlUnitPkg::AluRegState) || (state == controlUnitPkg::AluImmState) ||
		(state == controlUnitPkg::DefaultState) ||
		(state >= controlUnitPkg::LoadAddrState && state <= controlUnitPkg::LoadWriteState) ||
		(state >= controlUnitPkg::StoreAddrState && state <= controlUnitPkg::StoreWaitState) ||
		(state == controlUnitPkg::BranchState) || (state == controlUnitPkg::BranchTakeState);

	resetToFetch: assert property (@(posedge clk) disable iff (reset)
		(state == controlUnitPkg::ResetState) |=> (state == controlUnitPkg::FetchState))
		else $error("reset state was not followed by the fetch state");

	waitHolds: assert property (@(posedge clk) disable iff (reset)
		(inWait && !moc) |=> (state == $past(state)))
		else $error("wait state left while memory was not complete");

	stateInUse: assert property (@(posedge clk) disable iff (reset) inUse)
		else $error("sequencer reached an unused state");

endmodule

/* controlUnitTb.sv */
//////////////////////////////
// Testbench top with random stimulus, a reference
// next-state model and per-cycle comparison
//////////////////////////////
module controlUnitTb;

	localparam int ResetCycles = 10;
	localparam int RunCycles = 3000;
	localparam int FetchTimeout = 100;

	// Load and memory bits under check
	typedef struct packed
	{
		logic marLd;
		logic mdrLd;
		logic irLd;
		logic pcLd;
		logic rfLd;
		logic memEnable;
		logic readWrite;
	} loadBits_t;

	logic clk;
	logic reset;
	logic moc;
	logic cond;
	controlUnitPkg::opcode_t opcode;
	controlUnitPkg::datapathCtrl_t ctrl;
	controlUnitPkg::state_t state;

	controlUnitPkg::state_t predicted;
	logic primed;
	loadBits_t expBits;
	loadBits_t gotBits;
	int visits [32];
	logic [7:0] dispatchSeen;
	int takenCount;
	int notTakenCount;
	int holdCount;
	int waitCycles;
	int cycle;

	clockGen #(.Period(8)) clock_i
	(
		.clk(clk)
	);

	controlUnit dut_i
	(
		.clk(clk),
		.reset(reset),
		.opcode(opcode),
		.moc(moc),
		.cond(cond),
		.ctrl(ctrl),
		.state(state)
	);

	bind microSequencer controlUnitChecker checker_i
	(
		.clk(clk),
		.reset(reset),
		.moc(moc),
		.state(state)
	);

	// Routine entry by opcode class
	function automatic controlUnitPkg::state_t classEntry(input controlUnitPkg::opcode_t op);
		case (op)
			3'd0: return controlUnitPkg::AluRegState;
			3'd1: return controlUnitPkg::AluImmState;
			3'd2: return controlUnitPkg::LoadAddrState;
			3'd3: return controlUnitPkg::StoreAddrState;
			3'd4: return controlUnitPkg::BranchState;
			default: return controlUnitPkg::DefaultState;
		endcase
	endfunction

	function automatic controlUnitPkg::state_t expectedNext
	(
		input controlUnitPkg::state_t s,
		input controlUnitPkg::opcode_t op,
		input logic mocIn,
		input logic condIn
	);
		case (s)
			controlUnitPkg::ResetState: return controlUnitPkg::FetchState;
			controlUnitPkg::FetchState: return controlUnitPkg::FetchWaitState;
			controlUnitPkg::FetchWaitState:
				return mocIn ? controlUnitPkg::IrLoadState : controlUnitPkg::FetchWaitState;
			controlUnitPkg::IrLoadState: return classEntry(op);
			controlUnitPkg::LoadAddrState: return controlUnitPkg::LoadWaitState;
			controlUnitPkg::LoadWaitState:
				return mocIn ? controlUnitPkg::LoadWriteState : controlUnitPkg::LoadWaitState;
			controlUnitPkg::StoreAddrState: return controlUnitPkg::StoreDataState;
			controlUnitPkg::StoreDataState: return controlUnitPkg::StoreWaitState;
			controlUnitPkg::StoreWaitState:
				return mocIn ? controlUnitPkg::FetchState : controlUnitPkg::StoreWaitState;
			controlUnitPkg::BranchState:
				return condIn ? controlUnitPkg::BranchTakeState : controlUnitPkg::FetchState;
			// ALU, default, load write, branch take and unused states
			default: return controlUnitPkg::FetchState;
		endcase
	endfunction

	function automatic loadBits_t expectedBits(input controlUnitPkg::state_t s);
		loadBits_t b;
		b.marLd = (s == controlUnitPkg::FetchState) || (s == controlUnitPkg::LoadAddrState) ||
			(s == controlUnitPkg::StoreAddrState);
		b.mdrLd = (s == controlUnitPkg::LoadWaitState) || (s == controlUnitPkg::StoreDataState);
		b.irLd = (s == controlUnitPkg::IrLoadState);
		b.pcLd = (s == controlUnitPkg::FetchState) || (s == controlUnitPkg::BranchTakeState);
		b.rfLd = (s == controlUnitPkg::AluRegState) || (s == controlUnitPkg::AluImmState) ||
			(s == controlUnitPkg::LoadWriteState);
		b.memEnable = (s == controlUnitPkg::FetchWaitState) ||
			(s == controlUnitPkg::LoadWaitState) || (s == controlUnitPkg::StoreWaitState);
		b.readWrite = (s == controlUnitPkg::FetchWaitState) ||
			(s == controlUnitPkg::LoadWaitState);
		return b;
	endfunction

	function automatic loadBits_t observedBits(input controlUnitPkg::datapathCtrl_t c);
		loadBits_t b;
		b.marLd = c.marLd;
		b.mdrLd = c.mdrLd;
		b.irLd = c.irLd;
		b.pcLd = c.pcLd;
		b.rfLd = c.rfLd;
		b.memEnable = c.memEnable;
		b.readWrite = c.readWrite;
		return b;
	endfunction

	function automatic logic isRoutineState(input controlUnitPkg::state_t s);
		case (s)
			controlUnitPkg::ResetState, controlUnitPkg::FetchState,
			controlUnitPkg::FetchWaitState, controlUnitPkg::IrLoadState,
			controlUnitPkg::AluRegState, controlUnitPkg::AluImmState,
			controlUnitPkg::DefaultState, controlUnitPkg::LoadAddrState,
			controlUnitPkg::LoadWaitState, controlUnitPkg::LoadWriteState,
			controlUnitPkg::StoreAddrState, controlUnitPkg::StoreDataState,
			controlUnitPkg::StoreWaitState, controlUnitPkg::BranchState,
			controlUnitPkg::BranchTakeState:
				return 1'b1;
			default:
				return 1'b0;
		endcase
	endfunction

	task automatic announceFailure();
		$display("*** FAILED ***");
	endtask

	task automatic driveRandom();
		opcode = controlUnitPkg::opcode_t'($urandom_range(7, 0));
		moc = 1'($urandom_range(1, 0));
		cond = 1'($urandom_range(1, 0));
	endtask

	// Sampled before the state register takes its next value
	always @(posedge clk)
	begin
		if (reset)
		begin
			assert (ctrl == '0)
			else
			begin
				$display("** Error reset ctrl: expected %h, actual %h", 25'h0, ctrl);
				announceFailure();
				$fatal(1, "stopping at first error");
			end
			if (primed)
			begin
				assert (state == controlUnitPkg::ResetState)
				else
				begin
					$display("** Error reset state: expected %0d, actual %0d",
						controlUnitPkg::ResetState, state);
					announceFailure();
					$fatal(1, "stopping at first error");
				end
			end
			predicted = controlUnitPkg::ResetState;
			primed = 1'b1;
		end
		else
		begin
			assert (state == predicted)
			else
			begin
				$display("** Error next state: expected %0d, actual %0d", predicted, state);
				announceFailure();
				$fatal(1, "stopping at first error");
			end
			expBits = expectedBits(state);
			gotBits = observedBits(ctrl);
			assert (gotBits == expBits)
			else
			begin
				$display("** Error load bits in state %0d: expected %b, actual %b",
					state, expBits, gotBits);
				announceFailure();
				$fatal(1, "stopping at first error");
			end
			visits[state]++;
			if (state == controlUnitPkg::IrLoadState)
				dispatchSeen[opcode] = 1'b1;
			if (state == controlUnitPkg::BranchState && cond)
				takenCount++;
			if (state == controlUnitPkg::BranchState && !cond)
				notTakenCount++;
			if (expBits.memEnable && !moc)
				holdCount++;
			predicted = expectedNext(state, opcode, moc, cond);
		end
	end

	initial
	begin
		void'($urandom(32'h1141));
		reset = 1'b1;
		opcode = '0;
		moc = 1'b0;
		cond = 1'b0;
		primed = 1'b0;
		predicted = controlUnitPkg::ResetState;
		dispatchSeen = '0;
		takenCount = 0;
		notTakenCount = 0;
		holdCount = 0;
		for (int i = 0; i < 32; i++)
			visits[i] = 0;

		repeat (ResetCycles) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;
		driveRandom();

		// First fetch has to complete
		waitCycles = 0;
		while (state != controlUnitPkg::IrLoadState && waitCycles < FetchTimeout)
		begin
			@(negedge clk);
			driveRandom();
			waitCycles++;
		end
		assert (state == controlUnitPkg::IrLoadState)
		else
		begin
			$display("Error: the first fetch did not reach the IR load state in time");
			announceFailure();
			$fatal(1, "fetch timeout");
		end

		for (cycle = 0; cycle < RunCycles; cycle++)
		begin
			@(negedge clk);
			driveRandom();
		end

		for (int i = 0; i < 32; i++)
		begin
			if (isRoutineState(controlUnitPkg::state_t'(i)))
			begin
				assert (visits[i] > 0)
				else
				begin
					$display("Error: state %0d was never reached during the run", i);
					announceFailure();
					$fatal(1, "coverage hole");
				end
			end
		end
		assert (dispatchSeen == 8'hff && takenCount > 0 && notTakenCount > 0 && holdCount > 0)
		else
		begin
			$display("Error: some opcode class, branch outcome or memory stall never occurred");
			announceFailure();
			$fatal(1, "coverage hole");
		end

		$display("*** PASSED ***");
		$finish;
	end

endmodule

/* controlUnit.f */
controlUnitPkg.sv
instructionDecoder.sv
microstore.sv
microSequencer.sv
controlUnit.sv
clockGen.sv
controlUnitChecker.sv
controlUnitTb.sv

/* Makefile */
VERILATOR = verilator
VFLAGS = --binary --timing --assert
TOP = controlUnitTb
FILELIST = controlUnit.f
OBJDIR = obj_dir
PASS_MSG = *** PASSED ***

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)
	@out="$$(./$(OBJDIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF -- '$(PASS_MSG)'

clean:
	rm -rf $(OBJDIR)
